// File: design/vc_switch_pkg.sv
package vc_switch_pkg;

    // Word layout is {class, dest, payload}
    localparam int payload_width = 4;
    localparam int word_width = payload_width + 2;

    localparam int class_bit = word_width - 1;  // 0 selects VC0, 1 selects VC1
    localparam int dest_bit = word_width - 2;   // 0 selects D0, 1 selects D1

    localparam int threshold_width = 4;
    localparam int default_addr_width = 4;      // Depth of 16 words

endpackage

// File: design/vc_fifo.sv
module vc_fifo #(
    parameter int addr_width = vc_switch_pkg::default_addr_width
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     init,
    input  logic                                     push,
    input  logic                                     pop,
    input  logic [vc_switch_pkg::word_width-1:0]      data_in,
    input  logic [vc_switch_pkg::threshold_width-1:0] threshold,
    output logic [vc_switch_pkg::word_width-1:0]      data_out,
    output logic                                     full,
    output logic                                     empty,
    output logic                                     almost_full,
    output logic                                     almost_empty,
    output logic                                     error
);
    import vc_switch_pkg::*;

    localparam int depth = 1 << addr_width;

    logic [word_width-1:0] mem [depth];
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [addr_width:0]   count;  // One bit wider to hold a full count
    logic                  push_ok;
    logic                  pop_ok;

    assign push_ok = init && push && !full;
    assign pop_ok = init && pop && !empty;

    assign full = (int'(count) == depth);
    assign empty = (count == '0);
    assign almost_full = (int'(count) >= depth - int'(threshold));
    assign almost_empty = (int'(count) <= int'(threshold));

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power of two depth
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Read data is registered and returns to zero after each pop
    always_ff @(posedge clk) begin
        if (!reset) begin
            data_out <= '0;
        end else if (init) begin
            data_out <= pop_ok ? mem[rd_ptr] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            error <= 1'b0;
        end else if (init && ((push && full) || (pop && empty))) begin
            error <= 1'b1;  // Sticky until the next reset
        end
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (!reset)
        int'(count) <= depth
    ) else $error("vc_fifo count exceeds depth");

    data_out_idle_zero: assert property (
        @(posedge clk) disable iff (!reset)
        init && !pop |=> data_out == '0
    ) else $error("vc_fifo data_out not zero after a cycle without pop");

endmodule

// File: design/vc_ingress.sv
module vc_ingress (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                init,
    input  logic                                main_empty,
    input  logic                                vc0_almost_full,
    input  logic                                vc1_almost_full,
    input  logic [vc_switch_pkg::word_width-1:0] main_data,
    output logic                                main_pop,
    output logic                                vc0_push,
    output logic                                vc1_push,
    output logic [vc_switch_pkg::word_width-1:0] vc_data
);
    import vc_switch_pkg::*;

    logic in_flight;  // main_data carries a word this cycle
    logic to_vc1;

    // The class is unknown before the read, so both VCs must have room
    assign main_pop = init && !main_empty && !vc0_almost_full && !vc1_almost_full;

    always_ff @(posedge clk) begin
        if (!reset) begin
            in_flight <= 1'b0;
        end else if (init) begin
            in_flight <= main_pop;
        end
    end

    assign to_vc1 = main_data[class_bit];

    assign vc0_push = init && in_flight && !to_vc1;
    assign vc1_push = init && in_flight && to_vc1;
    assign vc_data = main_data;  // Both VC FIFOs see the word, one push strobes

    vc_push_exclusive: assert property (
        @(posedge clk) disable iff (!reset)
        !(vc0_push && vc1_push)
    ) else $error("vc_ingress pushed VC0 and VC1 together");

endmodule

// File: design/vc_arbiter.sv
module vc_arbiter (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                init,
    input  logic                                vc0_empty,
    input  logic                                vc1_empty,
    input  logic                                d0_almost_full,
    input  logic                                d1_almost_full,
    input  logic [vc_switch_pkg::word_width-1:0] vc0_data,
    input  logic [vc_switch_pkg::word_width-1:0] vc1_data,
    output logic                                vc0_pop,
    output logic                                vc1_pop,
    output logic                                d0_push,
    output logic                                d1_push,
    output logic [vc_switch_pkg::word_width-1:0] dest_data
);
    import vc_switch_pkg::*;

    logic                  dest_ready;
    logic                  granted_vc0;
    logic                  granted_vc1;
    logic                  word_valid;
    logic [word_width-1:0] word;

    // Destination is unknown before the read, so both D FIFOs must have room
    assign dest_ready = !d0_almost_full && !d1_almost_full;

    // VC0 has strict priority
    assign vc0_pop = init && dest_ready && !vc0_empty;
    assign vc1_pop = init && dest_ready && vc0_empty && !vc1_empty;

    always_ff @(posedge clk) begin
        if (!reset) begin
            granted_vc0 <= 1'b0;
            granted_vc1 <= 1'b0;
        end else if (init) begin
            granted_vc0 <= vc0_pop;
            granted_vc1 <= vc1_pop;
        end
    end

    assign word_valid = granted_vc0 || granted_vc1;
    assign word = granted_vc0 ? vc0_data : vc1_data;

    assign d0_push = init && word_valid && !word[dest_bit];
    assign d1_push = init && word_valid && word[dest_bit];
    assign dest_data = word;

    vc_pop_onehot: assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0({vc0_pop, vc1_pop})
    ) else $error("vc_arbiter popped VC0 and VC1 together");

endmodule

// File: design/vc_switch_top.sv
module vc_switch_top #(
    parameter int main_addr_width = vc_switch_pkg::default_addr_width,
    parameter int vc_addr_width = vc_switch_pkg::default_addr_width,
    parameter int dest_addr_width = vc_switch_pkg::default_addr_width
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     init,
    input  logic                                     push,
    input  logic [vc_switch_pkg::word_width-1:0]      data_in,
    input  logic [vc_switch_pkg::threshold_width-1:0] main_threshold,
    input  logic [vc_switch_pkg::threshold_width-1:0] vc_threshold,
    input  logic [vc_switch_pkg::threshold_width-1:0] dest_threshold,
    input  logic                                     d0_pop,
    input  logic                                     d1_pop,
    output logic                                     main_full,
    output logic                                     main_almost_full,
    output logic                                     d0_empty,
    output logic                                     d1_empty,
    output logic [vc_switch_pkg::word_width-1:0]      d0_data,
    output logic [vc_switch_pkg::word_width-1:0]      d1_data,
    output logic                                     error
);
    import vc_switch_pkg::*;

    logic [word_width-1:0] main_data;
    logic [word_width-1:0] vc_data;
    logic [word_width-1:0] vc0_data;
    logic [word_width-1:0] vc1_data;
    logic [word_width-1:0] dest_data;
    logic                  main_empty;
    logic                  main_pop;
    logic                  vc0_push;
    logic                  vc1_push;
    logic                  vc0_pop;
    logic                  vc1_pop;
    logic                  vc0_empty;
    logic                  vc1_empty;
    logic                  vc0_almost_full;
    logic                  vc1_almost_full;
    logic                  d0_push;
    logic                  d1_push;
    logic                  d0_almost_full;
    logic                  d1_almost_full;
    logic                  main_error;
    logic                  vc0_error;
    logic                  vc1_error;
    logic                  d0_error;
    logic                  d1_error;

    assign error = main_error | vc0_error | vc1_error | d0_error | d1_error;

    vc_fifo #(.addr_width(main_addr_width)) u_main_fifo (
        .clk          (clk),
        .reset        (reset),
        .init         (init),
        .push         (push),
        .pop          (main_pop),
        .data_in      (data_in),
        .threshold    (main_threshold),
        .data_out     (main_data),
        .full         (main_full),
        .empty        (main_empty),
        .almost_full  (main_almost_full),
        .almost_empty (),
        .error        (main_error)
    );

    vc_ingress u_ingress (
        .clk             (clk),
        .reset           (reset),
        .init            (init),
        .main_empty      (main_empty),
        .vc0_almost_full (vc0_almost_full),
        .vc1_almost_full (vc1_almost_full),
        .main_data       (main_data),
        .main_pop        (main_pop),
        .vc0_push        (vc0_push),
        .vc1_push        (vc1_push),
        .vc_data         (vc_data)
    );

    vc_fifo #(.addr_width(vc_addr_width)) u_vc0_fifo (
        .clk          (clk),
        .reset        (reset),
        .init         (init),
        .push         (vc0_push),
        .pop          (vc0_pop),
        .data_in      (vc_data),
        .threshold    (vc_threshold),
        .data_out     (vc0_data),
        .full         (),
        .empty        (vc0_empty),
        .almost_full  (vc0_almost_full),
        .almost_empty (),
        .error        (vc0_error)
    );

    vc_fifo #(.addr_width(vc_addr_width)) u_vc1_fifo (
        .clk          (clk),
        .reset        (reset),
        .init         (init),
        .push         (vc1_push),
        .pop          (vc1_pop),
        .data_in      (vc_data),
        .threshold    (vc_threshold),
        .data_out     (vc1_data),
        .full         (),
        .empty        (vc1_empty),
        .almost_full  (vc1_almost_full),
        .almost_empty (),
        .error        (vc1_error)
    );

    vc_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .init           (init),
        .vc0_empty      (vc0_empty),
        .vc1_empty      (vc1_empty),
        .d0_almost_full (d0_almost_full),
        .d1_almost_full (d1_almost_full),
        .vc0_data       (vc0_data),
        .vc1_data       (vc1_data),
        .vc0_pop        (vc0_pop),
        .vc1_pop        (vc1_pop),
        .d0_push        (d0_push),
        .d1_push        (d1_push),
        .dest_data      (dest_data)
    );

    vc_fifo #(.addr_width(dest_addr_width)) u_d0_fifo (
        .clk          (clk),
        .reset        (reset),
        .init         (init),
        .push         (d0_push),
        .pop          (d0_pop),
        .data_in      (dest_data),
        .threshold    (dest_threshold),
        .data_out     (d0_data),
        .full         (),
        .empty        (d0_empty),
        .almost_full  (d0_almost_full),
        .almost_empty (),
        .error        (d0_error)
    );

    vc_fifo #(.addr_width(dest_addr_width)) u_d1_fifo (
        .clk          (clk),
        .reset        (reset),
        .init         (init),
        .push         (d1_push),
        .pop          (d1_pop),
        .data_in      (dest_data),
        .threshold    (dest_threshold),
        .data_out     (d1_data),
        .full         (),
        .empty        (d1_empty),
        .almost_full  (d1_almost_full),
        .almost_empty (),
        .error        (d1_error)
    );

endmodule

// File: test/tb_vc_switch.sv
module tb_vc_switch;
    import vc_switch_pkg::*;

    localparam int depth = 1 << default_addr_width;
    localparam int wait_limit = 200;
    localparam int drain_limit = 2000;

    logic                       clk;
    logic                       reset;
    logic                       init;
    logic                       push;
    logic [word_width-1:0]      data_in;
    logic [threshold_width-1:0] main_threshold;
    logic [threshold_width-1:0] vc_threshold;
    logic [threshold_width-1:0] dest_threshold;
    logic                       d0_pop;
    logic                       d1_pop;
    logic                       main_full;
    logic                       main_almost_full;
    logic                       d0_empty;
    logic                       d1_empty;
    logic [word_width-1:0]      d0_data;
    logic [word_width-1:0]      d1_data;
    logic                       error;

    logic [31:0]           lfsr;
    logic [word_width-1:0] q00[$];  // Model queues named by class then dest
    logic [word_width-1:0] q01[$];
    logic [word_width-1:0] q10[$];
    logic [word_width-1:0] q11[$];
    logic [word_width-1:0] d1_log[$];  // Arrival order at D1

    vc_switch_top #(
        .main_addr_width (default_addr_width),
        .vc_addr_width   (default_addr_width),
        .dest_addr_width (default_addr_width)
    ) i_dut (
        .clk              (clk),
        .reset            (reset),
        .init             (init),
        .push             (push),
        .data_in          (data_in),
        .main_threshold   (main_threshold),
        .vc_threshold     (vc_threshold),
        .dest_threshold   (dest_threshold),
        .d0_pop           (d0_pop),
        .d1_pop           (d1_pop),
        .main_full        (main_full),
        .main_almost_full (main_almost_full),
        .d0_empty         (d0_empty),
        .d1_empty         (d1_empty),
        .d0_data          (d0_data),
        .d1_data          (d1_data),
        .error            (error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            value[i] = lfsr[0];
        end
    endtask

    task automatic make_word(input logic cls, input logic dst, output logic [word_width-1:0] w);
        logic [31:0] bits;
        random_bits(payload_width, bits);
        w = {cls, dst, bits[payload_width-1:0]};
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s]: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic int model_size();
        return q00.size() + q01.size() + q10.size() + q11.size();
    endfunction

    task automatic model_push(input logic [word_width-1:0] w);
        case ({w[class_bit], w[dest_bit]})
            2'b00: q00.push_back(w);
            2'b01: q01.push_back(w);
            2'b10: q10.push_back(w);
            default: q11.push_back(w);
        endcase
    endtask

    task automatic take_expected(input logic cls, input logic dst,
                                 output logic [word_width-1:0] expected, output logic found);
        expected = '0;
        case ({cls, dst})
            2'b00: found = (q00.size() > 0);
            2'b01: found = (q01.size() > 0);
            2'b10: found = (q10.size() > 0);
            default: found = (q11.size() > 0);
        endcase
        if (found) begin
            case ({cls, dst})
                2'b00: expected = q00.pop_front();
                2'b01: expected = q01.pop_front();
                2'b10: expected = q10.pop_front();
                default: expected = q11.pop_front();
            endcase
        end
    endtask

    // One cycle push, no look at the full flag
    task automatic drive_push(input logic [word_width-1:0] w);
        push = 1'b1;
        data_in = w;
        @(negedge clk);
        push = 1'b0;
        data_in = '0;
    endtask

    task automatic push_word(input logic [word_width-1:0] w);
        int waited;
        waited = 0;
        while (main_full) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                fail_run("Timed out waiting for the main FIFO to leave full");
            end
        end
        drive_push(w);
        model_push(w);
    endtask

    task automatic check_word(input string name, input logic dst,
                              input logic [word_width-1:0] w);
        logic [word_width-1:0] expected;
        logic                  found;
        check_value({name, " dest bit"}, dst, w[dest_bit]);
        take_expected(w[class_bit], dst, expected, found);
        if (!found) begin
            fail_run($sformatf("Word 0x%0h in %s matches no pushed word", w, name));
        end
        check_value(name, expected, w);
    endtask

    task automatic drain_words(input string name, input int n);
        int   received;
        int   cycles;
        logic popped0;
        logic popped1;
        received = 0;
        cycles = 0;
        popped0 = 1'b0;
        popped1 = 1'b0;
        while (received < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > drain_limit) begin
                fail_run($sformatf("Timed out draining D0 and D1 in %s", name));
            end
            if (popped0) begin
                check_word(name, 1'b0, d0_data);
                received++;
            end
            if (popped1) begin
                check_word(name, 1'b1, d1_data);
                d1_log.push_back(d1_data);
                received++;
            end
            popped0 = (received < n) && !d0_empty;  // Data returns one cycle later
            popped1 = (received < n) && !d1_empty;
            d0_pop = popped0;
            d1_pop = popped1;
        end
    endtask

    task automatic check_all_delivered(input string name);
        idle_cycles(10);
        check_value({name, " d0_empty"}, 1, d0_empty);
        check_value({name, " d1_empty"}, 1, d1_empty);
        check_value({name, " words left"}, 0, model_size());
    endtask

    task automatic test_reset_init();
        logic [word_width-1:0] w;
        int                    i;
        check_value("reset main_full", 0, main_full);
        check_value("reset main_almost_full", 0, main_almost_full);
        check_value("reset d0_empty", 1, d0_empty);
        check_value("reset d1_empty", 1, d1_empty);
        check_value("reset error", 0, error);
        check_value("reset d0_data", 0, d0_data);
        check_value("reset d1_data", 0, d1_data);
        for (i = 0; i < 4; i++) begin
            make_word(i[0], i[1], w);
            drive_push(w);  // init is low, so the word is ignored
        end
        idle_cycles(20);
        check_value("init low d0_empty", 1, d0_empty);
        check_value("init low d1_empty", 1, d1_empty);
    endtask

    task automatic test_routing();
        logic [31:0] bits;
        int          batch;
        int          i;
        for (batch = 0; batch < 2; batch++) begin
            for (i = 0; i < 24; i++) begin
                random_bits(word_width, bits);
                push_word(bits[word_width-1:0]);
            end
            drain_words("routing", 24);
        end
        check_all_delivered("routing");
        check_value("routing error", 0, error);
    endtask

    task automatic test_priority();
        logic [word_width-1:0] w;
        int                    i;
        for (i = 0; i < depth - int'(dest_threshold); i++) begin
            make_word(1'b0, 1'b0, w);
            push_word(w);
        end
        idle_cycles(30);  // D0 now sits at its almost full level
        for (i = 0; i < 4; i++) begin
            make_word(1'b1, 1'b1, w);
            push_word(w);
        end
        for (i = 0; i < 4; i++) begin
            make_word(1'b0, 1'b1, w);
            push_word(w);
        end
        idle_cycles(30);
        check_value("priority stall d1_empty", 1, d1_empty);
        d1_log.delete();
        drain_words("priority", model_size());
        check_all_delivered("priority");
        check_value("priority d1 count", 8, d1_log.size());
        for (i = 0; i < 8; i++) begin
            check_value("priority class order", (i >= 4), d1_log[i][class_bit]);
        end
    endtask

    task automatic test_main_flags();
        logic [word_width-1:0] w;
        int                    absorbed;
        int                    held;
        int                    i;
        main_threshold = 4'd4;
        // Single words settle fully, so D0 and VC0 each stop at depth minus threshold
        absorbed = (depth - int'(dest_threshold)) + (depth - int'(vc_threshold));
        for (i = 0; i < absorbed; i++) begin
            make_word(1'b0, 1'b0, w);
            push_word(w);
            idle_cycles(10);
        end
        check_value("main_flags almost_full empty", 0, main_almost_full);
        for (held = 1; held <= depth; held++) begin
            make_word(1'b0, 1'b0, w);
            push_word(w);
            idle_cycles(10);
            check_value("main_flags almost_full", held >= depth - int'(main_threshold),
                        main_almost_full);
            check_value("main_flags full", held == depth, main_full);
        end
    endtask

    task automatic test_error_flag();
        logic [word_width-1:0] w;
        check_value("error_flag before", 0, error);
        make_word(1'b0, 1'b0, w);
        drive_push(w);  // Main is full, so this word is dropped
        check_value("error_flag set", 1, error);
        idle_cycles(8);
        check_value("error_flag sticky", 1, error);
        drain_words("error_flag drain", model_size());
        check_all_delivered("error_flag");
        check_value("error_flag after drain", 1, error);
    endtask

    initial begin
        reset = 1'b0;
        init = 1'b0;
        push = 1'b0;
        data_in = '0;
        main_threshold = 4'd2;
        vc_threshold = 4'd2;
        dest_threshold = 4'd2;
        d0_pop = 1'b0;
        d1_pop = 1'b0;
        lfsr = 32'd92696;
        repeat (10) @(negedge clk);
        reset = 1'b1;
        test_reset_init();
        init = 1'b1;
        test_routing();
        test_priority();
        test_main_flags();
        test_error_flag();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: vc_switch.f
design/vc_switch_pkg.sv
design/vc_fifo.sv
design/vc_ingress.sv
design/vc_arbiter.sv
design/vc_switch_top.sv
test/tb_vc_switch.sv

// File: Bender.yml
package:
  name: vc_switch

sources:
  - design/vc_switch_pkg.sv
  - design/vc_fifo.sv
  - design/vc_ingress.sv
  - design/vc_arbiter.sv
  - design/vc_switch_top.sv
  - target: simulation
    files:
      - test/tb_vc_switch.sv
